// ==== arithmetic_logic_unit.sv ====
/*
 * Arithmetic logic unit
 * Combinational RV32I add, subtract, compare, logic and shift operations
 */

module arithmetic_logic_unit (
    input  integer_unit_pkg::data_word_t operand_a_i,
    input  integer_unit_pkg::data_word_t operand_b_i,
    input  integer_unit_pkg::alu_op_e    operation_i,
    input  logic                         data_valid_i,
    output integer_unit_pkg::data_word_t result_o,
    output logic                         data_valid_o
);

    import integer_unit_pkg::*;

    // Only the low 5 bits of operand B count for shifts
    logic [4:0] shift_amount;

    // Comparison flags shared by SLT and SLTU
    logic signed_less;
    logic unsigned_less;

    assign shift_amount  = operand_b_i[4:0];
    assign signed_less   = $signed(operand_a_i) < $signed(operand_b_i);
    assign unsigned_less = operand_a_i < operand_b_i;

    always_comb begin
        case (operation_i)
            ALU_ADD: result_o = operand_a_i + operand_b_i;
            ALU_SUB: result_o = operand_a_i - operand_b_i;

            // Set-less-than writes 0 or 1 into the whole word
            ALU_SLT:  result_o = {31'b0, signed_less};
            ALU_SLTU: result_o = {31'b0, unsigned_less};

            ALU_AND: result_o = operand_a_i & operand_b_i;
            ALU_OR:  result_o = operand_a_i | operand_b_i;
            ALU_XOR: result_o = operand_a_i ^ operand_b_i;

            ALU_SLL: result_o = operand_a_i << shift_amount;
            ALU_SRL: result_o = operand_a_i >> shift_amount;

            // Arithmetic shift replicates the sign bit of operand A
            ALU_SRA: result_o = $signed(operand_a_i) >>> shift_amount;

            default: result_o = '0;
        endcase
    end

    // No internal state, so the result is ready in the issue cycle
    assign data_valid_o = data_valid_i;

endmodule : arithmetic_logic_unit

// ==== division_unit.sv ====
/*
 * Sequential radix-2 restoring divider
 * Signed and unsigned quotient or remainder, RISC-V divide-by-zero results, idle flag
 */

module division_unit (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         clk_en_i,
    input  logic                         clear_i,
    input  integer_unit_pkg::data_word_t dividend_i,
    input  integer_unit_pkg::data_word_t divisor_i,
    input  integer_unit_pkg::div_op_e    operation_i,
    input  logic                         data_valid_i,
    output integer_unit_pkg::data_word_t quotient_o,
    output logic                         data_valid_o,
    output logic                         idle_o
);

    import integer_unit_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ZERO_DIVIDE,
        DIVIDE,
        DONE
    } div_state_e;

    div_state_e state_q, state_d;

    // Count 0 is the load cycle, counts 1 to 32 are the iterations
    logic [5:0] count_q, count_d;

    // Operands as issued
    data_word_t dividend_q;
    data_word_t divisor_q;
    div_op_e    op_q;

    // Working registers, quotient bits shift in where dividend bits shift out
    data_word_t rem_q;
    data_word_t quo_q;
    data_word_t div_abs_q;
    logic       neg_quot_q;
    logic       neg_rem_q;

    logic       is_signed;
    logic       dividend_neg;
    logic       divisor_neg;
    logic [32:0] shifted;
    logic [32:0] difference;
    data_word_t selected;

    assign is_signed    = (op_q == DIV) || (op_q == REM);
    assign dividend_neg = is_signed & dividend_q[31];
    assign divisor_neg  = is_signed & divisor_q[31];

    // One restoring step, bit 32 of the difference set means the trial subtract failed
    assign shifted    = {rem_q, quo_q[31]};
    assign difference = shifted - {1'b0, div_abs_q};

    // ==============================
    // Control
    // ==============================

    always_comb begin
        state_d = state_q;
        count_d = count_q;
        case (state_q)
            IDLE: begin
                if (data_valid_i) begin
                    state_d = (divisor_i == '0) ? ZERO_DIVIDE : DIVIDE;
                    count_d = '0;
                end
            end
            ZERO_DIVIDE: state_d = DONE;
            DIVIDE: begin
                count_d = count_q + 6'd1;
                if (count_q == 6'd32) begin
                    state_d = DONE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // Clear returns to idle even when the unit is frozen
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            count_q <= '0;
        end else if (clear_i) begin
            state_q <= IDLE;
            count_q <= '0;
        end else if (clk_en_i) begin
            state_q <= state_d;
            count_q <= count_d;
        end
    end

    // ==============================
    // Datapath
    // ==============================

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            case (state_q)
                IDLE: begin
                    if (data_valid_i) begin
                        dividend_q <= dividend_i;
                        divisor_q  <= divisor_i;
                        op_q       <= operation_i;
                    end
                end
                ZERO_DIVIDE: begin
                    // RISC-V gives all ones as quotient and the dividend as remainder
                    quo_q      <= '1;
                    rem_q      <= dividend_q;
                    neg_quot_q <= 1'b0;
                    neg_rem_q  <= 1'b0;
                end
                DIVIDE: begin
                    if (count_q == '0) begin
                        // Load cycle works on magnitudes and remembers the signs
                        quo_q      <= dividend_neg ? -dividend_q : dividend_q;
                        div_abs_q  <= divisor_neg ? -divisor_q : divisor_q;
                        rem_q      <= '0;
                        neg_quot_q <= dividend_neg ^ divisor_neg;
                        neg_rem_q  <= dividend_neg;
                    end else if (difference[32]) begin
                        rem_q <= shifted[31:0];
                        quo_q <= {quo_q[30:0], 1'b0};
                    end else begin
                        rem_q <= difference[31:0];
                        quo_q <= {quo_q[30:0], 1'b1};
                    end
                end
                default: ;
            endcase
        end
    end

    // Sign correction, the overflow case comes out as the most negative value
    always_comb begin
        if ((op_q == DIV) || (op_q == DIVU)) begin
            selected = neg_quot_q ? -quo_q : quo_q;
        end else begin
            selected = neg_rem_q ? -rem_q : rem_q;
        end
    end

    assign quotient_o = selected;

    // The result cycle only counts when the unit is enabled, so the pulse is never doubled
    assign data_valid_o = (state_q == DONE) & clk_en_i;
    assign idle_o       = (state_q == IDLE);

endmodule : division_unit

// ==== integer_unit.f ====
integer_unit_pkg.sv
arithmetic_logic_unit.sv
multiplication_unit.sv
division_unit.sv
integer_unit.sv
integer_unit_props.sv
integer_unit_tb.sv

// ==== integer_unit.sv ====
/*
 * Integer execution unit
 * Dispatches one operation per cycle to the ALU, multiplier or divider and merges the results
 */

module integer_unit #(
    parameter int unsigned MUL_PIPE_STAGES = 3
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            flush_i,
    input  logic                            mul_enable_i,
    input  logic                            div_enable_i,
    input  integer_unit_pkg::instr_packet_t ipacket_i,
    input  integer_unit_pkg::itu_uop_t      operation_i,
    input  integer_unit_pkg::itu_valid_t    data_valid_i,
    input  integer_unit_pkg::data_word_t    operand_1_i,
    input  integer_unit_pkg::data_word_t    operand_2_i,
    output integer_unit_pkg::data_word_t    result_o,
    output integer_unit_pkg::instr_packet_t ipacket_o,
    output logic                            data_valid_o,
    output logic                            div_idle_o
);

    import integer_unit_pkg::*;

    // ==============================
    // ALU
    // ==============================

    data_word_t    alu_result;
    logic          alu_valid;
    data_word_t    alu_result_out;
    instr_packet_t alu_ipacket_out;

    arithmetic_logic_unit i_alu (
        .operand_a_i  (operand_1_i),
        .operand_b_i  (operand_2_i),
        .operation_i  (operation_i.alu),
        .data_valid_i (data_valid_i.alu),
        .result_o     (alu_result),
        .data_valid_o (alu_valid)
    );

    assign alu_result_out = alu_valid ? alu_result : '0;

    // The ALU packet is the issue packet itself, a flush wipes it in the same cycle
    assign alu_ipacket_out = (alu_valid && !flush_i) ? ipacket_i : NO_OPERATION;

    // ==============================
    // Multiplier
    // ==============================

    data_word_t    mul_result;
    logic          mul_valid;
    data_word_t    mul_result_out;
    instr_packet_t mul_ipacket_out;

    // Packets shift in step with the multiplier stages
    instr_packet_t mul_ipacket_q [MUL_PIPE_STAGES];

    multiplication_unit #(
        .MUL_PIPE_STAGES (MUL_PIPE_STAGES)
    ) i_mul (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .clk_en_i       (mul_enable_i),
        .clear_i        (flush_i),
        .multiplicand_i (operand_1_i),
        .multiplier_i   (operand_2_i),
        .operation_i    (operation_i.mul),
        .data_valid_i   (data_valid_i.mul),
        .product_o      (mul_result),
        .data_valid_o   (mul_valid)
    );

    always_ff @(posedge clk_i) begin
        if (flush_i) begin
            for (int i = 0; i < MUL_PIPE_STAGES; i++) begin
                mul_ipacket_q[i] <= NO_OPERATION;
            end
        end else if (mul_enable_i) begin
            mul_ipacket_q[0] <= ipacket_i;
            for (int i = 1; i < MUL_PIPE_STAGES; i++) begin
                mul_ipacket_q[i] <= mul_ipacket_q[i-1];
            end
        end
    end

    assign mul_result_out  = mul_valid ? mul_result : '0;
    assign mul_ipacket_out = mul_valid ? mul_ipacket_q[MUL_PIPE_STAGES-1] : NO_OPERATION;

    // ==============================
    // Divider
    // ==============================

    data_word_t    div_result;
    logic          div_valid;
    data_word_t    div_result_out;
    instr_packet_t div_ipacket_out;

    // Only one division is in flight, so a single register holds its packet
    instr_packet_t div_ipacket_q;

    division_unit i_div (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clk_en_i     (div_enable_i),
        .clear_i      (flush_i),
        .dividend_i   (operand_1_i),
        .divisor_i    (operand_2_i),
        .operation_i  (operation_i.div),
        .data_valid_i (data_valid_i.div),
        .quotient_o   (div_result),
        .data_valid_o (div_valid),
        .idle_o       (div_idle_o)
    );

    always_ff @(posedge clk_i) begin
        if (flush_i) begin
            div_ipacket_q <= NO_OPERATION;
        end else if (data_valid_i.div) begin
            div_ipacket_q <= ipacket_i;
        end
    end

    assign div_result_out  = div_valid ? div_result : '0;
    assign div_ipacket_out = div_valid ? div_ipacket_q : NO_OPERATION;

    // ==============================
    // Output merge
    // ==============================

    // Idle units drive zeros, so an OR is enough as long as completions never collide
    assign result_o     = alu_result_out | mul_result_out | div_result_out;
    assign ipacket_o    = alu_ipacket_out | mul_ipacket_out | div_ipacket_out;
    assign data_valid_o = alu_valid | mul_valid | div_valid;

endmodule : integer_unit

// ==== integer_unit_pkg.sv ====
/*
 * Integer execution unit definitions
 * Data word, instruction packet, per-unit opcodes and per-unit valid/operation bundles
 */

package integer_unit_pkg;

    // ==============================
    // Data and packet types
    // ==============================

    // Operand and result word of the integer datapath
    typedef logic [31:0] data_word_t;

    // Instruction information that travels alongside an operation
    typedef struct packed {
        // Tag that identifies the instruction in flight
        logic [7:0] tag;
        // Destination register index
        logic [4:0] dest_reg;
        // Result must be written back to the register file
        logic       writeback;
    } instr_packet_t;

    // Empty slot, held by any flushed or idle stage
    localparam instr_packet_t NO_OPERATION = '0;

    // ==============================
    // Opcodes
    // ==============================

    // RV32I register-register operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // M extension multiplications, MUL returns the low word and the rest the high word
    typedef enum logic [1:0] {
        MUL,
        MULH,
        MULHSU,
        MULHU
    } mul_op_e;

    // M extension divisions
    typedef enum logic [1:0] {
        DIV,
        DIVU,
        REM,
        REMU
    } div_op_e;

    // One opcode field per functional unit
    typedef struct packed {
        alu_op_e alu;
        mul_op_e mul;
        div_op_e div;
    } itu_uop_t;

    // One valid bit per functional unit, at most one is set per cycle
    typedef struct packed {
        logic alu;
        logic mul;
        logic div;
    } itu_valid_t;

endpackage : integer_unit_pkg

// ==== integer_unit_props.sv ====
/*
 * Integer execution unit assertions
 * Output exclusivity, reset state and flush behavior
 */

module integer_unit_props (
    input logic       clk_i,
    input logic       rst_n_i,
    input logic       flush_i,
    input logic [2:0] data_valid_i,
    input logic       data_valid_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // ==============================
    // Properties
    // ==============================

    // Bit 2 of the valid bundle is the ALU, which may still answer right after a flush
    a_one_unit : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(data_valid_i))
        else $error("more than one unit valid");

    a_reset_quiet : assert property (@(posedge clk_i)
        !rst_n_i |-> !data_valid_o)
        else $error("output valid during reset");

    a_flush_quiet : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> (!data_valid_o || data_valid_i[2]))
        else $error("output valid after flush");

endmodule : integer_unit_props

bind integer_unit integer_unit_props i_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .data_valid_i (data_valid_i),
    .data_valid_o (data_valid_o)
);

// ==== integer_unit_tb.sv ====
/*
 * Integer execution unit testbench
 * Table driven ALU, multiplier and divider checks plus burst, stall and flush scenarios
 */

module integer_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import integer_unit_pkg::*;

    localparam int unsigned MUL_STAGES = 3;

    // One table row, unit 0 is the ALU, 1 the multiplier and 2 the divider
    typedef struct {
        int         unit;
        logic [3:0] op;
        data_word_t a;
        data_word_t b;
        logic [7:0] tag;
        bit         rnd;
        data_word_t exp;
    } row_t;

    logic          clk_i = 1'b0;
    logic          rst_n_i;
    logic          flush_i;
    logic          mul_enable_i;
    logic          div_enable_i;
    instr_packet_t ipacket_i;
    itu_uop_t      operation_i;
    itu_valid_t    data_valid_i;
    data_word_t    operand_1_i;
    data_word_t    operand_2_i;
    data_word_t    result_o;
    instr_packet_t ipacket_o;
    logic          data_valid_o;
    logic          div_idle_o;

    row_t        rows[$];
    logic [31:0] rng_state = 32'h23d0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    integer_unit #(
        .MUL_PIPE_STAGES (MUL_STAGES)
    ) i_dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .mul_enable_i (mul_enable_i),
        .div_enable_i (div_enable_i),
        .ipacket_i    (ipacket_i),
        .operation_i  (operation_i),
        .data_valid_i (data_valid_i),
        .operand_1_i  (operand_1_i),
        .operand_2_i  (operand_2_i),
        .result_o     (result_o),
        .ipacket_o    (ipacket_o),
        .data_valid_o (data_valid_o),
        .div_idle_o   (div_idle_o)
    );

    always #10 clk_i = ~clk_i;

    // Run limit, scaled by the table length
    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ==============================
    // Reference models
    // ==============================

    function automatic logic [31:0] xorshift_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic data_word_t alu_model(logic [3:0] op, data_word_t a, data_word_t b);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3: return (a < b) ? 32'd1 : 32'd0;
            4: return a & b;
            5: return a | b;
            6: return a ^ b;
            7: return a << b[4:0];
            8: return a >> b[4:0];
            default: return $signed(a) >>> b[4:0];
        endcase
    endfunction

    // The low 64 bits of a product do not depend on signedness once operands are extended
    function automatic data_word_t mul_model(logic [3:0] op, data_word_t a, data_word_t b);
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] p;
        x = (op != 3) ? {{32{a[31]}}, a} : {32'b0, a};
        y = (op < 2) ? {{32{b[31]}}, b} : {32'b0, b};
        p = x * y;
        return (op == 0) ? p[31:0] : p[63:32];
    endfunction

    function automatic data_word_t div_model(logic [3:0] op, data_word_t a, data_word_t b);
        logic               overflow;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] sres;
        overflow = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        sa = a;
        sb = b;
        sres = '0;
        if (b == '0) begin
            return (op < 2) ? 32'hFFFF_FFFF : a;
        end
        // Signed overflow keeps the dividend as quotient and leaves no remainder
        if (overflow && (op == 0 || op == 2)) begin
            return (op == 0) ? a : 32'd0;
        end
        case (op)
            0: sres = sa / sb;
            1: return a / b;
            2: sres = sa % sb;
            default: return a % b;
        endcase
        return sres;
    endfunction

    task automatic add_row(input int unit, input int op, input data_word_t a,
                           input data_word_t b, input bit rnd);
        row_t r;
        r.unit = unit;
        r.op   = op[3:0];
        r.a    = rnd ? xorshift_next() : a;
        r.b    = rnd ? xorshift_next() : b;
        r.tag  = 8'(rows.size() + 1);
        r.rnd  = rnd;
        case (unit)
            0: r.exp = alu_model(r.op, r.a, r.b);
            1: r.exp = mul_model(r.op, r.a, r.b);
            default: r.exp = div_model(r.op, r.a, r.b);
        endcase
        rows.push_back(r);
    endtask

    // ==============================
    // Stimulus tasks
    // ==============================

    task automatic report(input int idx, input string what, input bit ok);
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s", idx, what, ok ? "ok" : "FAIL");
    endtask

    // Issues one row and waits for its result, counting rising edges as latency
    task automatic apply_row(input int idx);
        row_t          r;
        instr_packet_t exp_pkt;
        string         name;
        int            lat;
        int            exp_lat;
        bit            ok;
        r = rows[idx];
        ok = 1;
        lat = 0;
        exp_lat = (r.unit == 0) ? 0 : (r.unit == 1) ? MUL_STAGES : (r.b == '0) ? 2 : 34;
        exp_pkt = '{tag: r.tag, dest_reg: r.tag[4:0], writeback: 1'b1};
        name = (r.unit == 0) ? "alu" : (r.unit == 1) ? "mul" : "div";
        @(negedge clk_i);
        ipacket_i    = exp_pkt;
        operand_1_i  = r.a;
        operand_2_i  = r.b;
        operation_i  = '{alu: alu_op_e'(r.op), mul: mul_op_e'(r.op[1:0]),
                         div: div_op_e'(r.op[1:0])};
        data_valid_i = '{alu: r.unit == 0, mul: r.unit == 1, div: r.unit == 2};
        #5;
        while (!data_valid_o) begin
            if (r.unit == 2 && lat > 0 && div_idle_o) begin
                $display("Divider idle flag went high at %0t while test %0d ran", $time, idx);
                ok = 0;
            end
            @(negedge clk_i);
            data_valid_i = '0;
            #5;
            lat++;
        end
        if (result_o !== r.exp) begin
            $display("Mismatch at %0t: test %0d result %h expected %h", $time, idx,
                     result_o, r.exp);
            ok = 0;
        end
        if (ipacket_o !== exp_pkt) begin
            $display("Mismatch at %0t: test %0d packet %h expected %h", $time, idx,
                     ipacket_o, exp_pkt);
            ok = 0;
        end
        if (lat != exp_lat) begin
            $display("Mismatch at %0t: test %0d latency %0d expected %0d", $time, idx,
                     lat, exp_lat);
            ok = 0;
        end
        @(negedge clk_i);
        data_valid_i = '0;
        #5;
        if (r.unit == 2 && !div_idle_o) begin
            $display("Divider stayed busy at %0t after test %0d finished", $time, idx);
            ok = 0;
        end
        report(idx, r.rnd ? {name, " random"} : name, ok);
    endtask

    // Four back-to-back multiplications, optionally with a 2 cycle enable gap
    task automatic mul_burst(input int idx, input bit stall);
        data_word_t exp_q[$];
        int         edges_q[$];
        int         issued;
        int         got;
        bit         ok;
        ok = 1;
        issued = 0;
        got = 0;
        for (int c = 0; c < 30 && got < 4; c++) begin
            @(negedge clk_i);
            data_valid_i = '0;
            mul_enable_i = !(stall && (c == 2 || c == 3));
            if (mul_enable_i && issued < 4) begin
                operand_1_i     = xorshift_next();
                operand_2_i     = xorshift_next();
                operation_i.mul = mul_op_e'(issued);
                ipacket_i       = '{tag: 8'(8'hA0 + issued), dest_reg: 5'd1, writeback: 1'b1};
                data_valid_i.mul = 1'b1;
                exp_q.push_back(mul_model(4'(issued), operand_1_i, operand_2_i));
                edges_q.push_back(0);
                issued++;
            end
            #5;
            if (data_valid_o && got < issued) begin
                if (edges_q[got] != MUL_STAGES) begin
                    $display("Mismatch at %0t: burst result %0d took %0d edges, expected %0d",
                             $time, got, edges_q[got], MUL_STAGES);
                    ok = 0;
                end
                if (result_o !== exp_q[got] || ipacket_o.tag !== 8'(8'hA0 + got)) begin
                    $display("Mismatch at %0t: burst result %0d is %h tag %h, expected %h",
                             $time, got, result_o, ipacket_o.tag, exp_q[got]);
                    ok = 0;
                end
                got++;
            end else if (data_valid_o) begin
                $display("Burst produced an extra result at %0t", $time);
                ok = 0;
            end else if (got < issued && edges_q[got] >= MUL_STAGES) begin
                $display("Burst result %0d did not arrive on time at %0t", got, $time);
                ok = 0;
                got++;
            end
            // The coming rising edge only advances the pipe while the enable is high
            for (int i = got; i < issued; i++) begin
                if (mul_enable_i) begin
                    edges_q[i] = edges_q[i] + 1;
                end
            end
        end
        if (got != 4) begin
            $display("Burst returned only %0d of 4 results", got);
            ok = 0;
        end
        @(negedge clk_i);
        data_valid_i = '0;
        mul_enable_i = 1'b1;
        report(idx, stall ? "mul burst with stall" : "mul burst", ok);
    endtask

    // Flush while a division and a multiplication are in flight
    task automatic flush_in_flight(input int idx);
        bit ok;
        ok = 1;
        @(negedge clk_i);
        operand_1_i      = 32'd1000;
        operand_2_i      = 32'd7;
        operation_i.div  = DIVU;
        ipacket_i        = '{tag: 8'hE0, dest_reg: 5'd2, writeback: 1'b1};
        data_valid_i     = '{alu: 1'b0, mul: 1'b0, div: 1'b1};
        @(negedge clk_i);
        operation_i.mul  = MUL;
        ipacket_i.tag    = 8'hE1;
        data_valid_i     = '{alu: 1'b0, mul: 1'b1, div: 1'b0};
        @(negedge clk_i);
        data_valid_i = '0;
        // The flush edge is the one that would move the product into the last stage
        @(negedge clk_i);
        flush_i = 1'b1;
        if (div_idle_o) begin
            $display("Divider was not busy when the flush arrived at %0t", $time);
            ok = 0;
        end
        @(negedge clk_i);
        flush_i = 1'b0;
        #5;
        if (!div_idle_o) begin
            $display("Divider did not return to idle after the flush at %0t", $time);
            ok = 0;
        end
        if (data_valid_o) begin
            $display("Flushed operation still produced a result at %0t", $time);
            ok = 0;
        end
        repeat (40) begin
            @(negedge clk_i);
            #5;
            if (data_valid_o) begin
                $display("Flushed operation still produced a result at %0t", $time);
                ok = 0;
            end
        end
        report(idx, "flush", ok);
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        mul_enable_i = 1'b1;
        div_enable_i = 1'b1;
        ipacket_i    = NO_OPERATION;
        operation_i  = '0;
        data_valid_i = '0;
        operand_1_i  = '0;
        operand_2_i  = '0;

        // ALU opcodes with edge operands, then random ones
        for (int op = 0; op < 10; op++) begin
            add_row(0, op, 32'h8000_0000, 32'hFFFF_FFE1, 0);
            add_row(0, op, '0, '0, 1);
        end
        add_row(0, 2, 32'h7FFF_FFFF, 32'h8000_0000, 0);
        add_row(0, 3, 32'h7FFF_FFFF, 32'h8000_0000, 0);

        // Multiplier signed corner cases
        for (int op = 0; op < 4; op++) begin
            add_row(1, op, 32'h8000_0000, 32'hFFFF_FFFF, 0);
            add_row(1, op, 32'hFFFF_FFFE, 32'h7FFF_FFFF, 0);
        end

        // Divider, with zero divisor and overflow rows
        for (int op = 0; op < 4; op++) begin
            add_row(2, op, 32'hFFFF_FF9C, 32'd7, 0);
            add_row(2, op, 32'h1234_5678, '0, 0);
            add_row(2, op, 32'h8000_0000, 32'hFFFF_FFFF, 0);
        end

        // Kept for after the flush scenario
        add_row(1, 0, 32'd12345, 32'hFFFF_FF00, 0);

        cycle_limit = rows.size() * 40 + 200;

        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;

        for (int i = 0; i < rows.size() - 1; i++) begin
            apply_row(i);
        end
        mul_burst(rows.size(), 0);
        mul_burst(rows.size() + 1, 1);
        flush_in_flight(rows.size() + 2);
        apply_row(rows.size() - 1);

        $display("Tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule : integer_unit_tb

// ==== multiplication_unit.sv ====
/*
 * Pipelined multiplier
 * Signed, unsigned and mixed 32x32 products, low or high word, MUL_PIPE_STAGES latency
 */

module multiplication_unit #(
    parameter int unsigned MUL_PIPE_STAGES = 3
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         clk_en_i,
    input  logic                         clear_i,
    input  integer_unit_pkg::data_word_t multiplicand_i,
    input  integer_unit_pkg::data_word_t multiplier_i,
    input  integer_unit_pkg::mul_op_e    operation_i,
    input  logic                         data_valid_i,
    output integer_unit_pkg::data_word_t product_o,
    output logic                         data_valid_o
);

    import integer_unit_pkg::*;

    // Operand signedness decoded from the opcode
    logic sign_a;
    logic sign_b;

    // First stage, operands extended to 33 bits so one signed multiply covers all cases
    logic signed [32:0] operand_a_q;
    logic signed [32:0] operand_b_q;

    logic signed [65:0] product_wide;
    logic [63:0]        product_last;

    // Opcode and valid bit travel with the data through every stage
    mul_op_e                    op_q [MUL_PIPE_STAGES];
    logic [MUL_PIPE_STAGES-1:0] valid_q;

    always_comb begin
        case (operation_i)
            MUL, MULH: begin
                sign_a = 1'b1;
                sign_b = 1'b1;
            end
            MULHSU: begin
                sign_a = 1'b1;
                sign_b = 1'b0;
            end
            default: begin
                sign_a = 1'b0;
                sign_b = 1'b0;
            end
        endcase
    end

    // ==============================
    // Data pipeline
    // ==============================

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            operand_a_q <= {sign_a & multiplicand_i[31], multiplicand_i};
            operand_b_q <= {sign_b & multiplier_i[31], multiplier_i};
            op_q[0]     <= operation_i;
            for (int i = 1; i < MUL_PIPE_STAGES; i++) begin
                op_q[i] <= op_q[i-1];
            end
        end
    end

    // Only the low 64 bits of the 66 bit product are meaningful
    assign product_wide = operand_a_q * operand_b_q;

    generate
        if (MUL_PIPE_STAGES == 1) begin : g_single_stage
            // Product is formed straight out of the operand registers
            assign product_last = product_wide[63:0];
        end else begin : g_product_pipe
            logic [63:0] product_q [MUL_PIPE_STAGES-1];

            always_ff @(posedge clk_i) begin
                if (clk_en_i) begin
                    product_q[0] <= product_wide[63:0];
                    for (int i = 1; i < MUL_PIPE_STAGES - 1; i++) begin
                        product_q[i] <= product_q[i-1];
                    end
                end
            end

            assign product_last = product_q[MUL_PIPE_STAGES-2];
        end
    endgenerate

    // ==============================
    // Valid pipeline
    // ==============================

    // A clear empties the pipe even while the clock enable is low
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (clear_i) begin
            valid_q <= '0;
        end else if (clk_en_i) begin
            valid_q[0] <= data_valid_i;
            for (int i = 1; i < MUL_PIPE_STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // MUL keeps the low word, the high variants the upper one
    assign product_o = (op_q[MUL_PIPE_STAGES-1] == MUL) ? product_last[31:0]
                                                        : product_last[63:32];

    assign data_valid_o = valid_q[MUL_PIPE_STAGES-1];

endmodule : multiplication_unit

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the integer unit testbench with Verilator

verilator --binary --timing --assert -Wno-fatal \
    --top-module integer_unit_tb -f integer_unit.f \
    -o integer_unit_sim > build.log 2>&1 \
    && ./obj_dir/integer_unit_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" \
    || { echo "no pass result in sim.log"; exit 1; }
